/* compile.f */
+incdir+include
logic/gpio_pkg.sv
logic/gpio_pad_cell.sv
logic/gpio_event_collect.sv
logic/gpio_apb_regs.sv
logic/gpio_bank.sv
test/tb_gpio_bank.sv

/* logic/gpio_apb_regs.sv */
module gpio_apb_regs import gpio_pkg::*; #(
	parameter int N_PADS = 16
) (
	input  logic              clk_sys,
	input  logic              rst_n,

	input  apb_req_t          apb_req,
	output apb_rsp_t          apb_rsp,

	output pad_ctrl_t         pad_ctrl [N_PADS],
	input  logic [N_PADS-1:0] pin_in,

	input  logic [N_PADS-1:0] status,
	output logic [N_PADS-1:0] status_clr,
	output logic [N_PADS-1:0] irq_en
);

	logic [N_PADS-1:0]   reg_out;
	logic [N_PADS-1:0]   reg_oe;
	logic [2*N_PADS-1:0] reg_mode;
	logic [N_PADS-1:0]   reg_irq_en;

	gpio_reg_e   reg_sel;
	logic        access;
	logic        addr_hit;
	logic        wr_bad;
	logic        wr_ok;
	logic [31:0] rd_word;

	assign reg_sel = gpio_reg_e'(apb_req.paddr);

	// Zero wait states, every access phase completes
	assign access = apb_req.psel && apb_req.penable;

	// Address decode and read mux
	always_comb begin
		addr_hit = 1'b1;
		rd_word  = '0;
		case (reg_sel)
			REG_OUT:    rd_word = 32'(reg_out);
			REG_OE:     rd_word = 32'(reg_oe);
			REG_IN:     rd_word = 32'(pin_in);
			REG_MODE:   rd_word = 32'(reg_mode);
			REG_STATUS: rd_word = 32'(status);
			REG_IRQ_EN: rd_word = 32'(reg_irq_en);
			default:    addr_hit = 1'b0; // Unmapped offset
		endcase
	end

	assign wr_bad = apb_req.pwrite && (reg_sel == REG_IN);
	assign wr_ok  = access && apb_req.pwrite && addr_hit && !wr_bad;

	always_comb begin
		apb_rsp.pready  = access;
		apb_rsp.pslverr = access && (!addr_hit || wr_bad);
		apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_word : '0;
	end

	// Register writes commit at the edge ending the access phase
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			reg_out    <= '0;
			reg_oe     <= '0;
			reg_mode   <= '0; // All pins EDGE_NONE
			reg_irq_en <= '0;
		end else if (wr_ok) begin
			case (reg_sel)
				REG_OUT:    reg_out    <= apb_req.pwdata[N_PADS-1:0];
				REG_OE:     reg_oe     <= apb_req.pwdata[N_PADS-1:0];
				REG_MODE:   reg_mode   <= apb_req.pwdata[2*N_PADS-1:0];
				REG_IRQ_EN: reg_irq_en <= apb_req.pwdata[N_PADS-1:0];
				default: ; // STATUS handled by the clear mask
			endcase
		end
	end

	// W1C mask, live only during the access phase of a STATUS write
	assign status_clr = (wr_ok && reg_sel == REG_STATUS) ?
		apb_req.pwdata[N_PADS-1:0] : '0;

	assign irq_en = reg_irq_en;

	// Repack the flat registers into per-pin control
	always_comb begin
		for (int i = 0; i < N_PADS; i++) begin
			pad_ctrl[i].out  = reg_out[i];
			pad_ctrl[i].oe   = reg_oe[i];
			pad_ctrl[i].mode = edge_mode_e'(reg_mode[2*i +: 2]);
		end
	end

endmodule

/* logic/gpio_bank.sv */
module gpio_bank import gpio_pkg::*; #(
	parameter int N_PADS = 16
) (
	input  logic              clk_sys,
	input  logic              rst_n,

	input  apb_req_t          apb_req,
	output apb_rsp_t          apb_rsp,

	output logic [N_PADS-1:0] padout,
	output logic [N_PADS-1:0] padoe,
	input  logic [N_PADS-1:0] padin,

	output logic              irq
);

	pad_ctrl_t         pad_ctrl [N_PADS];
	logic [N_PADS-1:0] pin_in;
	logic [N_PADS-1:0] pin_event;
	logic [N_PADS-1:0] status;
	logic [N_PADS-1:0] status_clr;
	logic [N_PADS-1:0] irq_en;

	gpio_apb_regs #(
		.N_PADS (N_PADS)
	) u_regs (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.pad_ctrl   (pad_ctrl),
		.pin_in     (pin_in),
		.status     (status),
		.status_clr (status_clr),
		.irq_en     (irq_en)
	);

	// One cell per pin
	for (genvar i = 0; i < N_PADS; i++) begin : g_pad
		gpio_pad_cell u_pad (
			.clk_sys   (clk_sys),
			.rst_n     (rst_n),
			.ctrl      (pad_ctrl[i]),
			.padout    (padout[i]),
			.padoe     (padoe[i]),
			.padin     (padin[i]),
			.pin_in    (pin_in[i]),
			.pin_event (pin_event[i])
		);
	end

	gpio_event_collect #(
		.N_PADS (N_PADS)
	) u_collect (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.pin_event  (pin_event),
		.status_clr (status_clr),
		.irq_en     (irq_en),
		.status     (status),
		.irq        (irq)
	);

endmodule

/* logic/gpio_event_collect.sv */
module gpio_event_collect #(
	parameter int N_PADS = 16
) (
	input  logic              clk_sys,
	input  logic              rst_n,

	input  logic [N_PADS-1:0] pin_event,
	input  logic [N_PADS-1:0] status_clr,
	input  logic [N_PADS-1:0] irq_en,

	output logic [N_PADS-1:0] status,
	output logic              irq
);

	logic [N_PADS-1:0] status_nxt;
	logic [N_PADS-1:0] irq_pend;

	// New event beats a clear on the same bit
	always_comb begin
		status_nxt = status & ~status_clr;
		status_nxt = status_nxt | pin_event;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			status <= '0;
		else
			status <= status_nxt;
	end

	assign irq_pend = status & irq_en; // Enabled and pending

	// Level interrupt, follows status in the same cycle
	assign irq = |irq_pend;

endmodule

/* logic/gpio_pad_cell.sv */
module gpio_pad_cell import gpio_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,

	input  pad_ctrl_t ctrl,

	output logic      padout,
	output logic      padoe,
	input  logic      padin,

	output logic      pin_in,
	output logic      pin_event
);

	logic sync_q1;
	logic sync_q2;
	logic hist_q;
	logic rise;
	logic fall;
	logic edge_hit;

	// Output copy flops sit next to the pin
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			padout <= 1'b0;
			padoe  <= 1'b0;
		end else begin
			padout <= ctrl.out;
			padoe  <= ctrl.oe;
		end
	end

	// Two-flop synchroniser plus one history flop
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
			hist_q  <= 1'b0;
		end else begin
			sync_q1 <= padin;
			sync_q2 <= sync_q1;
			hist_q  <= sync_q2;
		end
	end

	assign pin_in = sync_q2;

	assign rise = sync_q2 && !hist_q;
	assign fall = !sync_q2 && hist_q;

	always_comb begin
		case (ctrl.mode)
			EDGE_RISE: edge_hit = rise;
			EDGE_FALL: edge_hit = fall;
			EDGE_BOTH: edge_hit = rise || fall;
			default:   edge_hit = 1'b0;
		endcase
	end

	// Registered event, one cycle wide
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			pin_event <= 1'b0;
		else
			pin_event <= edge_hit;
	end

endmodule

/* logic/gpio_pkg.sv */
package gpio_pkg;

	// APB request from the bus master
	typedef struct packed {
		logic [7:0]  paddr;   // Byte address within the block
		logic        pwrite;
		logic        psel;
		logic        penable;
		logic [31:0] pwdata;
	} apb_req_t;

	// APB response back to the master
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Register map, byte offsets
	typedef enum logic [7:0] {
		REG_OUT    = 8'h00, // Output value
		REG_OE     = 8'h04, // Output enable
		REG_IN     = 8'h08, // Synchronised input, read only
		REG_MODE   = 8'h0C, // Two bits per pin
		REG_STATUS = 8'h10, // Sticky edge flags, W1C
		REG_IRQ_EN = 8'h14  // Interrupt mask
	} gpio_reg_e;

	// Edge detect mode of one pin
	typedef enum logic [1:0] {
		EDGE_NONE = 2'd0,
		EDGE_RISE = 2'd1,
		EDGE_FALL = 2'd2,
		EDGE_BOTH = 2'd3
	} edge_mode_e;

	// Control of a single pad cell
	typedef struct packed {
		logic       out;
		logic       oe;
		edge_mode_e mode;
	} pad_ctrl_t;

endpackage

/* include/apb_bfm_tasks.svh */
`ifndef APB_BFM_TASKS_SVH
`define APB_BFM_TASKS_SVH

// Setup phase, then access phase, then idle
task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		output logic err);
	@(negedge clk_sys);
	apb_req.paddr   = addr;
	apb_req.pwrite  = 1'b1;
	apb_req.psel    = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwdata  = data;
	@(negedge clk_sys);
	apb_req.penable = 1'b1;
	@(posedge clk_sys);
	err = apb_rsp.pslverr; // Sampled at the edge ending access
	@(negedge clk_sys);
	apb_req = '0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
	@(negedge clk_sys);
	apb_req.paddr   = addr;
	apb_req.pwrite  = 1'b0;
	apb_req.psel    = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwdata  = '0;
	@(negedge clk_sys);
	apb_req.penable = 1'b1;
	@(posedge clk_sys);
	data = apb_rsp.prdata;
	err  = apb_rsp.pslverr;
	@(negedge clk_sys);
	apb_req = '0;
endtask

// New pin levels on the falling edge
task automatic pad_drive(input logic [$bits(padin)-1:0] value);
	@(negedge clk_sys);
	padin = value;
endtask

`endif

/* test/tb_gpio_bank.sv */
module tb_gpio_bank import gpio_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_PADS = 16;
	localparam int N_OUT  = 40; // Output path rounds
	localparam int N_IN   = 40;
	localparam int N_EDGE = 60;
	localparam int N_CLR  = 20;

	// Roughly 3 cycles per APB transfer, 5 per pin change, doubled for margin
	localparam int MAX_CYCLES = 2 * (14 * N_OUT + 8 * N_IN + 8 * N_EDGE + 14 * N_CLR + 100);

	logic              clk_sys;
	logic              rst_n;
	apb_req_t          apb_req;
	apb_rsp_t          apb_rsp;
	logic [N_PADS-1:0] padout;
	logic [N_PADS-1:0] padoe;
	logic [N_PADS-1:0] padin;
	logic              irq;

	int          errors = 0;
	int          cycles = 0;
	logic [31:0] rng_state;

	// Mirrors of the register file and the status model
	logic [N_PADS-1:0]   mir_out;
	logic [N_PADS-1:0]   mir_oe;
	logic [2*N_PADS-1:0] mir_mode;
	logic [N_PADS-1:0]   mir_irq_en;
	logic [N_PADS-1:0]   model_status;
	logic [N_PADS-1:0]   pins_prev; // Last settled padin

	gpio_bank #(
		.N_PADS (N_PADS)
	) u_gpio_bank (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.padout  (padout),
		.padoe   (padoe),
		.padin   (padin),
		.irq     (irq)
	);

	`include "apb_bfm_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// The zero wait state slave raises pready in every access phase and only there
	pready_in_access: assert property (@(posedge clk_sys) disable iff (!rst_n)
		apb_rsp.pready == (apb_req.psel && apb_req.penable))
	else begin
		errors++;
		$display("pready did not match the APB access phase at %0t", $time);
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Events a pin change should raise under each pin's mode
	function automatic logic [N_PADS-1:0] expected_events(input logic [N_PADS-1:0] old_v,
			input logic [N_PADS-1:0] new_v, input logic [2*N_PADS-1:0] mode);
		logic [N_PADS-1:0] ev;
		ev = '0;
		for (int i = 0; i < N_PADS; i++) begin
			case (edge_mode_e'(mode[2*i +: 2]))
				EDGE_RISE: ev[i] = new_v[i] && !old_v[i];
				EDGE_FALL: ev[i] = !new_v[i] && old_v[i];
				EDGE_BOTH: ev[i] = new_v[i] != old_v[i];
				default:   ev[i] = 1'b0;
			endcase
		end
		return ev;
	endfunction

	function automatic logic expected_irq();
		return |(model_status & mir_irq_en);
	endfunction

	task automatic check_value(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", test, expected, actual);
		end
	endtask

	task automatic read_expect(input string test, input logic [7:0] addr,
			input logic [31:0] expected);
		logic [31:0] data;
		logic        err;
		apb_read(addr, data, err);
		check_value({test, " data"}, expected, data);
		check_value({test, " pslverr"}, 32'd0, 32'(err));
	endtask

	task automatic write_reg(input string test, input logic [7:0] addr, input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		check_value({test, " pslverr"}, 32'd0, 32'(err));
	endtask

	// Drive pins, let the sync chain and collector settle, then update the model
	task automatic apply_pins(input logic [N_PADS-1:0] value);
		pad_drive(value);
		repeat (4) @(posedge clk_sys);
		model_status |= expected_events(pins_prev, value, mir_mode);
		pins_prev = value;
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] data;
		logic        err;
		apb_req      = '0;
		padin        = '0;
		rst_n        = 1'b0;
		rng_state    = 32'hcf2e5d42;
		mir_out      = '0;
		mir_oe       = '0;
		mir_mode     = '0;
		mir_irq_en   = '0;
		model_status = '0;
		pins_prev    = '0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		// Reset values
		check_value("reset padout", '0, padout);
		check_value("reset padoe", '0, padoe);
		check_value("reset irq", '0, irq);
		read_expect("reset out", REG_OUT, '0);
		read_expect("reset oe", REG_OE, '0);
		read_expect("reset in", REG_IN, '0);
		read_expect("reset mode", REG_MODE, '0);
		read_expect("reset status", REG_STATUS, '0);
		read_expect("reset irq_en", REG_IRQ_EN, '0);

		// Pads follow the output registers two edges after the access ends
		for (int n = 0; n < N_OUT; n++) begin
			r = next_random();
			write_reg("out write", REG_OUT, r);
			check_value("padout one edge after write", mir_out, padout);
			mir_out = r[N_PADS-1:0];
			@(negedge clk_sys);
			check_value("padout two edges after write", mir_out, padout);
			r = next_random();
			write_reg("oe write", REG_OE, r);
			check_value("padoe one edge after write", mir_oe, padoe);
			mir_oe = r[N_PADS-1:0];
			@(negedge clk_sys);
			check_value("padoe two edges after write", mir_oe, padoe);
			read_expect("out readback", REG_OUT, mir_out);
			read_expect("oe readback", REG_OE, mir_oe);
		end

		// Input path with MODE still none and no events
		for (int n = 0; n < N_IN; n++) begin
			r = next_random();
			apply_pins(r[N_PADS-1:0]);
			read_expect("in readback", REG_IN, pins_prev);
		end

		// Edge detection and interrupt
		r = next_random();
		write_reg("mode write", REG_MODE, r);
		mir_mode = r[2*N_PADS-1:0];
		r = next_random();
		write_reg("irq_en write", REG_IRQ_EN, r);
		mir_irq_en = r[N_PADS-1:0];
		for (int n = 0; n < N_EDGE; n++) begin
			r = next_random();
			apply_pins(r[N_PADS-1:0]);
			read_expect("edge status", REG_STATUS, model_status);
			check_value("edge irq", 32'(expected_irq()), 32'(irq));
		end

		// Write-one-to-clear
		for (int n = 0; n < N_CLR; n++) begin
			r = next_random();
			apply_pins(r[N_PADS-1:0]);
			r = next_random();
			write_reg("status clear", REG_STATUS, r);
			model_status &= ~r[N_PADS-1:0];
			read_expect("status after clear", REG_STATUS, model_status);
			check_value("irq after clear", 32'(expected_irq()), 32'(irq));
		end
		write_reg("status full clear", REG_STATUS, 32'h0000_ffff);
		model_status = '0;
		read_expect("status after full clear", REG_STATUS, '0);
		check_value("irq after full clear", '0, 32'(irq));

		// Error responses
		apb_read(8'h18, data, err);
		check_value("read 0x18 pslverr", 32'd1, 32'(err));
		check_value("read 0x18 prdata", '0, data);
		apb_read(8'h40, data, err);
		check_value("read 0x40 pslverr", 32'd1, 32'(err));
		check_value("read 0x40 prdata", '0, data);
		apb_write(8'h18, next_random(), err);
		check_value("write 0x18 pslverr", 32'd1, 32'(err));
		apb_write(8'h40, next_random(), err);
		check_value("write 0x40 pslverr", 32'd1, 32'(err));
		apb_write(REG_IN, next_random(), err);
		check_value("write in pslverr", 32'd1, 32'(err));
		read_expect("out after errors", REG_OUT, mir_out);
		read_expect("oe after errors", REG_OE, mir_oe);
		read_expect("in after errors", REG_IN, pins_prev);
		read_expect("mode after errors", REG_MODE, mir_mode);
		read_expect("status after errors", REG_STATUS, model_status);
		read_expect("irq_en after errors", REG_IRQ_EN, mir_irq_en);

		$display("Run complete after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
